// ==== verilog/cfg_pkg.sv ====
`default_nettype none

package cfg_pkg;

    // --------------------
    // spi frame geometry
    // --------------------
    localparam int INSTR_HEADER_LEN = 16;                          // r/w + byte cnt + addr
    localparam int CFG_DATA_LEN     = 8;                           // one data byte
    localparam int MOSI_DATA_WIDTH  = INSTR_HEADER_LEN + CFG_DATA_LEN; // full frame, 24
    localparam int REG_ADDR_WIDTH   = 13;                          // register address field
    localparam int BIT_CNT_WIDTH    = $clog2(MOSI_DATA_WIDTH);     // counts 0..23

    localparam logic       FRAME_WRITE = 1'b0;                     // r/w bit, 0 = write
    localparam logic [1:0] ONE_BYTE    = 2'b00;                    // byte count, single byte

    // spi clock divider
    localparam int SPI_HALF_PERIOD = 2;                            // clk_20 cycles per half
    localparam int SPI_DIV_WIDTH   = $clog2(SPI_HALF_PERIOD + 1);

    // --------------------
    // power-up and led
    // --------------------
    localparam int POR_COUNT_WIDTH = 16;
    localparam logic [POR_COUNT_WIDTH-1:0] POR_START_COUNT = 16'hFFFE; // start strobe here
    localparam int LED_CNT_WIDTH   = 21;                           // msb blinks led 0

    // --------------------
    // register table
    // --------------------
    localparam int CFG_ENTRY_COUNT = 9;
    localparam int ENTRY_IDX_WIDTH = 4;
    localparam logic [ENTRY_IDX_WIDTH-1:0] FIRST_ADC_ENTRY = 4'd3; // adc writes start here

    // target of one table entry
    typedef enum logic [1:0] {
        DEV_AD9517 = 2'd0,      // clock chip
        DEV_ADC0   = 2'd1,
        DEV_ADC1   = 2'd2
    } cfg_dev_t;

    // 24-bit three-wire frame, sent msb first
    typedef struct packed {
        logic                      rw;        // 0 = write
        logic [1:0]                byte_cnt;  // 00 = one byte
        logic [REG_ADDR_WIDTH-1:0] reg_addr;
        logic [CFG_DATA_LEN-1:0]   data;
    } spi_frame_t;

    // rom word, also the request to the spi master
    typedef struct packed {
        cfg_dev_t   dev;
        spi_frame_t frame;
    } cfg_entry_t;

    // active-low chip selects
    typedef struct packed {
        logic ad9517;
        logic adc0;
        logic adc1;
    } cs_n_t;

endpackage

`default_nettype wire

// ==== verilog/board_supervisor.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_supervisor import cfg_pkg::*; (
    input  wire        clk_20,
    input  wire        rst_20,
    input  wire        i_cfg_done,      // level from sequencer
    output logic       o_cfg_start,     // one-cycle strobe after power-up
    output logic [3:0] o_pl_led
);

    logic [POR_COUNT_WIDTH-1:0] por_cnt;   // power-up timer
    logic [LED_CNT_WIDTH-1:0]   led_cnt;   // free-running blink counter
    logic                       led_on;    // set once config is done

    // --------------------
    // power-up timer
    // --------------------
    always_ff @(posedge clk_20) begin
        if (rst_20) begin
            por_cnt <= '0;
        end else if (por_cnt != '1) begin  // saturate at max
            por_cnt <= por_cnt + 1'b1;
        end
    end

    // count passes this value only once per reset
    assign o_cfg_start = (por_cnt == POR_START_COUNT);

    // --------------------
    // status led
    // --------------------
    always_ff @(posedge clk_20) begin
        if (rst_20) begin
            led_on <= 1'b0;
        end else if (i_cfg_done) begin
            led_on <= 1'b1;                // sticky until reset
        end
    end

    always_ff @(posedge clk_20) begin
        if (rst_20) begin
            led_cnt <= '0;
        end else if (led_on) begin
            led_cnt <= led_cnt + 1'b1;     // wraps, msb toggles every 2^20
        end
    end

    assign o_pl_led = {3'b111, led_cnt[LED_CNT_WIDTH-1]}; // leds 1..3 always lit

endmodule

`default_nettype wire

// ==== verilog/cfg_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfg_rom import cfg_pkg::*; (
    input  wire [ENTRY_IDX_WIDTH-1:0] i_entry_idx,
    output cfg_entry_t                o_entry
);

    // one-byte write to a given device
    function automatic cfg_entry_t wr_entry(
        input cfg_dev_t                  dev,
        input logic [REG_ADDR_WIDTH-1:0] addr,
        input logic [CFG_DATA_LEN-1:0]   data
    );
        cfg_entry_t e;
        e.dev            = dev;
        e.frame.rw       = FRAME_WRITE;
        e.frame.byte_cnt = ONE_BYTE;
        e.frame.reg_addr = addr;
        e.frame.data     = data;
        return e;
    endfunction

    // --------------------
    // register table
    // --------------------
    always_comb begin
        case (i_entry_idx)
            // ad9517 clock chip
            4'd0: o_entry = wr_entry(DEV_AD9517, 13'h000, 8'h99); // serial port config
            4'd1: o_entry = wr_entry(DEV_AD9517, 13'h010, 8'h7C); // pll power up
            4'd2: o_entry = wr_entry(DEV_AD9517, 13'h232, 8'h01); // io update
            // adc0, only after pll lock
            4'd3: o_entry = wr_entry(DEV_ADC0, 13'h008, 8'h00);   // normal power
            4'd4: o_entry = wr_entry(DEV_ADC0, 13'h014, 8'h01);   // twos complement
            4'd5: o_entry = wr_entry(DEV_ADC0, 13'h0FF, 8'h01);   // transfer
            // adc1, same settings
            4'd6: o_entry = wr_entry(DEV_ADC1, 13'h008, 8'h00);
            4'd7: o_entry = wr_entry(DEV_ADC1, 13'h014, 8'h01);
            4'd8: o_entry = wr_entry(DEV_ADC1, 13'h0FF, 8'h01);
            default: begin
                o_entry = '{dev: DEV_AD9517, frame: '0};  // never issued
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfg_sequencer import cfg_pkg::*; (
    input  wire                        clk_20,
    input  wire                        rst_20,
    input  wire                        i_cfg_start,     // strobe from supervisor
    input  wire                        i_ad9517_locked, // clock chip pll lock
    output logic [ENTRY_IDX_WIDTH-1:0] o_entry_idx,     // rom address
    output logic                       o_spi_start,     // one frame request
    input  wire                        i_spi_done,      // frame finished
    output logic                       o_cfg_done
);

    typedef enum logic [2:0] {
        ST_IDLE,        // wait for start strobe
        ST_ISSUE,       // pulse spi start
        ST_WAIT_FRAME,  // frame on the bus
        ST_WAIT_LOCK,   // hold adc writes until pll lock
        ST_DONE         // all entries written
    } seq_state_t;

    seq_state_t                 state;
    logic [ENTRY_IDX_WIDTH-1:0] idx_next;   // entry after the current one
    logic                       last_entry; // current entry is the final one

    assign idx_next   = o_entry_idx + 1'b1;
    assign last_entry = (idx_next == ENTRY_IDX_WIDTH'(CFG_ENTRY_COUNT));

    // --------------------
    // table walk
    // --------------------
    always_ff @(posedge clk_20) begin
        if (rst_20) begin
            state       <= ST_IDLE;
            o_entry_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_cfg_start) begin      // later strobes are ignored
                        o_entry_idx <= '0;
                        state       <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    state <= ST_WAIT_FRAME;     // start lasts one cycle
                end
                ST_WAIT_FRAME: begin
                    if (i_spi_done) begin
                        if (last_entry) begin
                            state <= ST_DONE;   // index stays on last entry
                        end else begin
                            o_entry_idx <= idx_next;
                            if (idx_next == FIRST_ADC_ENTRY) begin
                                state <= ST_WAIT_LOCK;  // clock chip phase over
                            end else begin
                                state <= ST_ISSUE;
                            end
                        end
                    end
                end
                ST_WAIT_LOCK: begin
                    if (i_ad9517_locked) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;           // held until reset
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // moore outputs
    assign o_spi_start = (state == ST_ISSUE);
    assign o_cfg_done  = (state == ST_DONE);   // one cycle after last spi done

endmodule

`default_nettype wire

// ==== verilog/spi_3wire_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_3wire_master import cfg_pkg::*; (
    input  wire             clk_20,
    input  wire             rst_20,
    input  wire             i_start,   // capture entry and send
    input  wire cfg_entry_t i_entry,
    output logic            o_done,    // one-cycle, with cs rising
    output cs_n_t           o_cs_n,
    output logic            o_sclk,
    output logic            o_sdio
);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,   // 24 sclk periods
        SPI_TAIL     // half period before cs release
    } spi_state_t;

    spi_state_t                 state;
    logic [MOSI_DATA_WIDTH-1:0] shreg;    // frame, msb leaves first
    logic [BIT_CNT_WIDTH-1:0]   bit_cnt;  // bits already clocked
    logic [SPI_DIV_WIDTH-1:0]   div_cnt;  // half period divider
    logic                       div_end;  // last cycle of a half period
    cs_n_t                      cs_sel;   // decoded select for i_entry

    assign div_end = (div_cnt == SPI_DIV_WIDTH'(SPI_HALF_PERIOD - 1));

    // one select low per device
    always_comb begin
        cs_sel = '1;
        case (i_entry.dev)
            DEV_AD9517: cs_sel.ad9517 = 1'b0;
            DEV_ADC0:   cs_sel.adc0   = 1'b0;
            DEV_ADC1:   cs_sel.adc1   = 1'b0;
            default:    cs_sel        = '1;   // unused code, no select
        endcase
    end

    // payload, loaded at start and shifted on falling sclk
    always_ff @(posedge clk_20) begin
        if (state == SPI_IDLE && i_start) begin
            shreg <= i_entry.frame;
        end else if (state == SPI_SHIFT && div_end && o_sclk) begin
            shreg <= shreg << 1;
        end
    end

    // --------------------
    // frame control
    // --------------------
    always_ff @(posedge clk_20) begin
        if (rst_20) begin
            state   <= SPI_IDLE;
            o_cs_n  <= '1;
            o_sclk  <= 1'b0;
            o_sdio  <= 1'b0;
            o_done  <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else begin
            o_done <= 1'b0;                          // pulse by default
            case (state)
                SPI_IDLE: begin
                    if (i_start) begin
                        o_cs_n  <= cs_sel;           // cs falls next cycle
                        o_sdio  <= i_entry.frame[MOSI_DATA_WIDTH-1]; // first bit early
                        o_sclk  <= 1'b0;
                        bit_cnt <= '0;
                        div_cnt <= '0;
                        state   <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT: begin
                    if (div_end) begin
                        div_cnt <= '0;
                        if (!o_sclk) begin
                            o_sclk <= 1'b1;          // slave samples here
                        end else begin
                            o_sclk <= 1'b0;
                            if (bit_cnt == BIT_CNT_WIDTH'(MOSI_DATA_WIDTH - 1)) begin
                                state <= SPI_TAIL;   // last falling edge
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                o_sdio  <= shreg[MOSI_DATA_WIDTH-2]; // next bit, sclk low
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                SPI_TAIL: begin
                    if (div_end) begin
                        div_cnt <= '0;
                        o_cs_n  <= '1;               // release bus
                        o_sdio  <= 1'b0;
                        o_done  <= 1'b1;
                        state   <= SPI_IDLE;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfg_top import cfg_pkg::*; (
    input  wire        clk_20,
    input  wire        rst_20,
    input  wire        i_ad9517_locked,  // pll lock from clock chip
    output logic       o_cfg_done,
    output cs_n_t      o_cs_n,           // ad9517, adc0, adc1
    output logic       o_spi_sclk,
    output logic       o_spi_sdio,       // write only, no turnaround
    output logic [3:0] o_pl_led
);

    logic                       cfg_start;  // power-up strobe
    logic [ENTRY_IDX_WIDTH-1:0] entry_idx;
    cfg_entry_t                 entry;      // rom word for entry_idx
    logic                       spi_start;
    logic                       spi_done;

    // --------------------
    // power-up and led
    // --------------------
    board_supervisor board_supervisor_i (
        .clk_20      (clk_20),
        .rst_20      (rst_20),
        .i_cfg_done  (o_cfg_done),
        .o_cfg_start (cfg_start),
        .o_pl_led    (o_pl_led)
    );

    // --------------------
    // device config
    // --------------------
    cfg_sequencer cfg_sequencer_i (
        .clk_20          (clk_20),
        .rst_20          (rst_20),
        .i_cfg_start     (cfg_start),
        .i_ad9517_locked (i_ad9517_locked),
        .o_entry_idx     (entry_idx),
        .o_spi_start     (spi_start),
        .i_spi_done      (spi_done),
        .o_cfg_done      (o_cfg_done)
    );

    cfg_rom cfg_rom_i (
        .i_entry_idx (entry_idx),
        .o_entry     (entry)
    );

    spi_3wire_master spi_3wire_master_i (
        .clk_20  (clk_20),
        .rst_20  (rst_20),
        .i_start (spi_start),
        .i_entry (entry),
        .o_done  (spi_done),
        .o_cs_n  (o_cs_n),
        .o_sclk  (o_spi_sclk),
        .o_sdio  (o_spi_sdio)
    );

endmodule

`default_nettype wire

// ==== tb/cfg_top_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfg_top_assertions (
    input wire       clk_20,
    input wire       rst_20,
    input wire [2:0] i_cs_n,       // ad9517, adc0, adc1
    input wire       i_sclk,
    input wire       i_cfg_done
);

    // shared bus, one device at a time
    cs_one_low: assert property (@(posedge clk_20) disable iff (rst_20) $onehot0(~i_cs_n))
        else $error("more than one chip select low");

    sclk_idle: assert property (@(posedge clk_20) disable iff (rst_20)
        (i_cs_n == 3'b111) |-> !i_sclk)
        else $error("sclk high with no chip select low");

    done_sticky: assert property (@(posedge clk_20) disable iff (rst_20) !$fell(i_cfg_done))
        else $error("o_cfg_done fell outside reset");

endmodule

bind cfg_top cfg_top_assertions cfg_top_assertions_i (
    .clk_20     (clk_20),
    .rst_20     (rst_20),
    .i_cs_n     (o_cs_n),
    .i_sclk     (o_spi_sclk),
    .i_cfg_done (o_cfg_done)
);

`default_nettype wire

// ==== tb/tb_cfg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cfg_top import cfg_pkg::*; ();

    localparam int         RESET_CYCLES = 16;
    localparam int         START_MARGIN = 8;                        // cs may trail the strobe
    localparam int         START_LIMIT  = int'(POR_START_COUNT) + 64;
    localparam int         FRAME_LIMIT  = 160;                      // one frame plus seq gap
    localparam int         LED_LOW_MIN  = 1 << (LED_CNT_WIDTH - 1); // msb of blink counter
    localparam int         LED_MARGIN   = 16;
    localparam int         MAX_FRAMES   = 16;
    localparam logic [2:0] CS_IDLE      = 3'b111;

    logic        clk_20;
    logic        rst_20;
    logic        lock;                       // drives i_ad9517_locked
    logic        cfg_done;
    logic [2:0]  cs_n;                       // ad9517, adc0, adc1
    logic        sclk;
    logic        sdio;
    logic [3:0]  pl_led;

    logic        rst_q  = 1'b1;              // reset as the DUT saw it
    logic        lock_q = 1'b0;
    logic [31:0] rel_cyc = '0;               // posedges since release
    logic        prev_sclk = 1'b0;
    logic [2:0]  prev_cs = CS_IDLE;
    logic [23:0] shift = '0;                 // frame being built
    logic [5:0]  shift_bits = '0;
    logic [4:0]  frame_cnt = '0;
    logic [23:0] frame_data [0:MAX_FRAMES-1];
    logic [2:0]  frame_cs   [0:MAX_FRAMES-1];
    logic [5:0]  frame_bits [0:MAX_FRAMES-1];
    logic        seen_cs = 1'b0;
    logic [31:0] first_cs_cyc = '0;
    logic        adc_early = 1'b0;           // adc selected while unlocked

    logic [31:0] lfsr_state = 32'd89999;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cfg_top cfg_top_i (
        .clk_20          (clk_20),
        .rst_20          (rst_20),
        .i_ad9517_locked (lock),
        .o_cfg_done      (cfg_done),
        .o_cs_n          (cs_n),
        .o_spi_sclk      (sclk),
        .o_spi_sdio      (sdio),
        .o_pl_led        (pl_led)
    );

    initial begin
        clk_20 = 1'b0;
        forever #20 clk_20 = ~clk_20;        // 40 ns period
    end

    // --------------------
    // spi frame monitor
    // --------------------
    always @(posedge clk_20) begin
        rst_q   <= rst_20;                   // copies taken at the DUT clock edge
        lock_q  <= lock;
        rel_cyc <= rst_20 ? 32'd0 : rel_cyc + 32'd1;
    end

    always @(negedge clk_20) begin
        if (rst_q) begin
            prev_sclk  <= 1'b0;
            prev_cs    <= CS_IDLE;
            shift_bits <= '0;
            frame_cnt  <= '0;
            seen_cs    <= 1'b0;
            adc_early  <= 1'b0;
        end else begin
            prev_sclk <= sclk;
            prev_cs   <= cs_n;
            if (cs_n != CS_IDLE) begin
                if (!seen_cs) begin
                    seen_cs      <= 1'b1;
                    first_cs_cyc <= rel_cyc;   // first select after release
                end
                if (sclk && !prev_sclk) begin  // rising sclk with sdio stable
                    shift      <= {shift[22:0], sdio};
                    shift_bits <= shift_bits + 6'd1;
                end
            end else if (prev_cs != CS_IDLE) begin
                if (frame_cnt < 5'(MAX_FRAMES)) begin
                    frame_data[frame_cnt] <= shift;
                    frame_cs[frame_cnt]   <= prev_cs;
                    frame_bits[frame_cnt] <= shift_bits;
                    frame_cnt             <= frame_cnt + 5'd1;
                end
                shift_bits <= '0;
            end
            if ((!cs_n[1] || !cs_n[0]) && !lock_q) begin
                adc_early <= 1'b1;
            end
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [23:0] model_frame(input int idx);
        case (idx)                               // top three bits give a one-byte write
            0:       return {3'b000, 13'h000, 8'h99};
            1:       return {3'b000, 13'h010, 8'h7C};   // pll power
            2:       return {3'b000, 13'h232, 8'h01};   // update
            3, 6:    return {3'b000, 13'h008, 8'h00};
            4, 7:    return {3'b000, 13'h014, 8'h01};
            default: return {3'b000, 13'h0FF, 8'h01};   // transfer
        endcase
    endfunction

    function automatic logic [2:0] model_cs(input int idx);
        if (idx < int'(FIRST_ADC_ENTRY)) return 3'b011;          // clock chip
        else if (idx < int'(FIRST_ADC_ENTRY) + 3) return 3'b101; // adc0
        else return 3'b110;                                      // adc1
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    // --------------------
    // reporting
    // --------------------
    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s expected 0x%0h actual 0x%0h", test, exp, act);
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %s", msg);
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-28s ok", test);
        end else begin
            $display("test %-28s %0d error(s)", test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // hold reset, check idle outputs, release
    task automatic apply_reset(input string test);
        @(negedge clk_20);
        rst_20 = 1'b1;
        lock   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_20);
        if (cs_n !== CS_IDLE) report_mismatch({test, " cs_n"}, 32'(CS_IDLE), 32'(cs_n));
        if (sclk !== 1'b0) report_mismatch({test, " sclk"}, 32'd0, 32'(sclk));
        if (sdio !== 1'b0) report_mismatch({test, " sdio"}, 32'd0, 32'(sdio));
        if (cfg_done !== 1'b0) report_mismatch({test, " done"}, 32'd0, 32'(cfg_done));
        if (pl_led !== 4'b1110) report_mismatch({test, " led"}, 32'hE, 32'(pl_led));
        rst_20 = 1'b0;
        finish_test(test);
    endtask

    task automatic wait_frames(input logic [4:0] count, input int limit, input string test);
        int n = 0;
        while (frame_cnt < count && n < limit) begin
            @(negedge clk_20);
            n++;
        end
        if (frame_cnt < count) report_problem($sformatf("%s timed out waiting for frame %0d",
                                                        test, count));
    endtask

    task automatic check_frames(input string test, input int first, input int last);
        int i;
        for (i = first; i <= last; i++) begin
            if (frame_bits[i] !== 6'd24)
                report_mismatch($sformatf("%s entry %0d bits", test, i), 32'd24,
                                32'(frame_bits[i]));
            if (frame_data[i] !== model_frame(i))
                report_mismatch($sformatf("%s entry %0d frame", test, i),
                                32'(model_frame(i)), 32'(frame_data[i]));
            if (frame_cs[i] !== model_cs(i))
                report_mismatch($sformatf("%s entry %0d cs_n", test, i),
                                32'(model_cs(i)), 32'(frame_cs[i]));
        end
    endtask

    // one full configuration pass after reset release
    task automatic run_sequence(input string tag, output logic [31:0] start_cyc);
        logic [31:0] delay;
        int          n = 0;
        while (!seen_cs && n < START_LIMIT) begin
            @(negedge clk_20);
            n++;
        end
        if (!seen_cs) report_problem({tag, " no chip select fell after power-up delay"});
        else if (first_cs_cyc < 32'(POR_START_COUNT))
            report_mismatch({tag, "_start_delay"}, 32'(POR_START_COUNT), first_cs_cyc);
        else if (first_cs_cyc > 32'(POR_START_COUNT) + 32'(START_MARGIN))
            report_mismatch({tag, "_start_delay"}, 32'(POR_START_COUNT) + 32'(START_MARGIN),
                            first_cs_cyc);
        start_cyc = first_cs_cyc;
        finish_test({tag, "_start_delay"});
        wait_frames(5'(FIRST_ADC_ENTRY), 3 * FRAME_LIMIT, {tag, "_clock_chip_frames"});
        check_frames({tag, "_clock_chip_frames"}, 0, int'(FIRST_ADC_ENTRY) - 1);
        finish_test({tag, "_clock_chip_frames"});
        take_random(8, delay);
        delay = delay + 32'd4;               // lock low for 4..259 cycles
        for (n = 0; n < int'(delay); n++) @(negedge clk_20);
        if (frame_cnt !== 5'(FIRST_ADC_ENTRY))
            report_mismatch({tag, "_lock_wait frames"}, 32'(FIRST_ADC_ENTRY),
                            32'(frame_cnt));
        lock = 1'b1;
        wait_frames(5'd9, 6 * FRAME_LIMIT, {tag, "_lock_wait"});
        check_frames({tag, "_lock_wait"}, int'(FIRST_ADC_ENTRY), 8);
        if (adc_early) report_problem({tag, " adc chip select fell before pll lock"});
        finish_test({tag, "_lock_wait"});
        n = 0;
        while (cfg_done !== 1'b1 && n < 16) begin
            @(negedge clk_20);
            n++;
        end
        if (cfg_done !== 1'b1) report_problem({tag, " o_cfg_done did not rise"});
        else if (frame_cnt !== 5'd9) report_mismatch({tag, "_done_rise frames"}, 32'd9,
                                                     32'(frame_cnt));
        finish_test({tag, "_done_rise"});
    endtask

    task automatic check_led();
        int   low_cycles = 0;
        logic done_drop = 1'b0;
        logic upper_bad = 1'b0;
        while (pl_led[0] !== 1'b1 && low_cycles < LED_LOW_MIN + LED_MARGIN) begin
            @(negedge clk_20);
            low_cycles++;
            if (cfg_done !== 1'b1) done_drop = 1'b1;
            if (pl_led[3:1] !== 3'b111) upper_bad = 1'b1;
        end
        if (done_drop) report_problem("o_cfg_done fell while waiting for LED 0");
        if (upper_bad) report_problem("LEDs 1 to 3 went low");
        if (pl_led[0] !== 1'b1) report_problem("LED 0 never rose after done");
        else if (low_cycles < LED_LOW_MIN)
            report_mismatch("led_blink low cycles", 32'(LED_LOW_MIN), 32'(low_cycles));
        finish_test("led_blink");
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        logic [31:0] start_first;
        logic [31:0] start_again;
        logic [31:0] cut;
        int          n;
        rst_20 = 1'b1;
        lock   = 1'b0;
        apply_reset("after_reset");
        run_sequence("first", start_first);
        check_led();
        apply_reset("restart_reset");
        n = 0;
        while (!seen_cs && n < START_LIMIT) begin
            @(negedge clk_20);
            n++;
        end
        if (!seen_cs) report_problem("no chip select fell before the mid-run reset");
        lock = 1'b1;                         // let the cut land in either phase
        take_random(9, cut);
        for (n = 0; n < int'(cut) + 20; n++) @(negedge clk_20);
        if (cfg_done === 1'b1) report_problem("configuration ended before the mid-run reset");
        apply_reset("restart_cut");
        run_sequence("restart", start_again);
        if (start_again !== start_first) report_mismatch("restart_same_delay", start_first,
                                                         start_again);
        finish_test("restart_same_delay");
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/cfg_pkg.sv
verilog/board_supervisor.sv
verilog/cfg_rom.sv
verilog/cfg_sequencer.sv
verilog/spi_3wire_master.sv
verilog/cfg_top.sv
tb/cfg_top_assertions.sv
tb/tb_cfg_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cfg_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_cfg_top -Mdir obj_dir

./obj_dir/Vtb_cfg_top 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
